/* hw/sprite_params.svh */
`ifndef SPRITE_PARAMS_SVH
`define SPRITE_PARAMS_SVH

// horizontal timing in pixels
`define H_VISIBLE       640
`define H_SYNC_START    656
`define H_SYNC_END      752
`define H_TOTAL         800

// vertical timing in lines
`define V_VISIBLE       480
`define V_SYNC_START    490
`define V_SYNC_END      492
`define V_TOTAL         525

`define TILE_SHIFT      4   // 16x16 tiles

`define NUM_COINS       4
`define COIN_POINTS     7

// palette indices
`define IDX_BLACK       0
`define IDX_SKY         1
`define IDX_TILE_EDGE   6
`define IDX_TILE_BODY   7
`define IDX_COIN        12
`define IDX_PLAYER      20

`endif

/* hw/sprite_pkg.sv */
`include "sprite_params.svh"

package sprite_pkg;

	typedef logic [9:0] coord_t;      // pixel position
	typedef logic [5:0] tile_idx_t;   // tile row or column
	typedef logic [4:0] color_idx_t;  // palette entry
	typedef logic [6:0] score_t;
	typedef logic [`NUM_COINS-1:0] coin_mask_t;

	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	typedef struct packed {
		coord_t draw_x;
		coord_t draw_y;
		logic   hs;
		logic   vs;
		logic   blank;  // low outside the visible area
	} scan_t;

	// answer of one layer for one pixel
	typedef struct packed {
		logic       opaque;
		color_idx_t idx;
	} layer_px_t;

	// all coins sit on the same row
	localparam tile_idx_t COIN_ROW [`NUM_COINS] = '{6'd20, 6'd20, 6'd20, 6'd20};
	localparam tile_idx_t COIN_COL [`NUM_COINS] = '{6'd5, 6'd12, 6'd20, 6'd30};

endpackage

/* hw/vga_timing.sv */
`timescale 1ns/10ps
`include "sprite_params.svh"

module vga_timing
	import sprite_pkg::*;
(
	input  logic  pixel_clk,
	input  logic  arst_n,
	output scan_t scan,
	output logic  frame_tick
);

	coord_t h_next;
	coord_t v_next;

	// next position, wraps at the end of line and frame
	always_comb
	begin
		h_next = scan.draw_x + 10'd1;
		v_next = scan.draw_y;
		if (scan.draw_x == coord_t'(`H_TOTAL - 1))
		begin
			h_next = '0;
			if (scan.draw_y == coord_t'(`V_TOTAL - 1))
				v_next = '0;
			else
				v_next = scan.draw_y + 10'd1;
		end
	end

	// sync and blank come from the next count so they line up with the counters
	always_ff @(posedge pixel_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			scan.draw_x <= '0;
			scan.draw_y <= '0;
			scan.hs     <= 1'b1;
			scan.vs     <= 1'b1;
			scan.blank  <= 1'b1;  // 0,0 is a visible pixel
			frame_tick  <= 1'b0;
		end
		else
		begin
			scan.draw_x <= h_next;
			scan.draw_y <= v_next;
			scan.hs     <= !((h_next >= `H_SYNC_START) && (h_next < `H_SYNC_END));
			scan.vs     <= !((v_next >= `V_SYNC_START) && (v_next < `V_SYNC_END));
			scan.blank  <= (h_next < `H_VISIBLE) && (v_next < `V_VISIBLE);
			frame_tick  <= (h_next == '0) && (v_next == coord_t'(`V_VISIBLE)); // first blank line
		end
	end

	a_count_range: assert property (@(posedge pixel_clk) disable iff (!arst_n)
		(scan.draw_x < `H_TOTAL) && (scan.draw_y < `V_TOTAL));

endmodule

/* hw/tile_layer.sv */
`timescale 1ns/10ps
`include "sprite_params.svh"

module tile_layer
	import sprite_pkg::*;
(
	input  logic      pixel_clk,
	input  logic      arst_n,
	input  scan_t     scan,
	output layer_px_t tile_px
);

	// fixed map, floor from this row down plus both side walls
	localparam tile_idx_t FLOOR_ROW = 6'd27;
	localparam tile_idx_t LEFT_COL  = 6'd0;
	localparam tile_idx_t RIGHT_COL = 6'd39;

	tile_idx_t tile_row;
	tile_idx_t tile_col;
	logic [`TILE_SHIFT-1:0] in_row;  // pixel row inside the tile
	logic      solid;
	layer_px_t px_next;

	always_comb
	begin
		tile_col = tile_idx_t'(scan.draw_x >> `TILE_SHIFT);
		tile_row = tile_idx_t'(scan.draw_y >> `TILE_SHIFT);
		in_row   = scan.draw_y[`TILE_SHIFT-1:0];

		solid = (tile_row >= FLOOR_ROW) || (tile_col == LEFT_COL) || (tile_col == RIGHT_COL);

		px_next.opaque = solid;
		// top pixel row of a tile gets the edge colour
		if (in_row == '0)
			px_next.idx = color_idx_t'(`IDX_TILE_EDGE);
		else
			px_next.idx = color_idx_t'(`IDX_TILE_BODY);
	end

	always_ff @(posedge pixel_clk or negedge arst_n)
	begin
		if (!arst_n)
			tile_px <= '0;
		else
			tile_px <= px_next;
	end

endmodule

/* hw/coin_layer.sv */
`timescale 1ns/10ps
`include "sprite_params.svh"

module coin_layer
	import sprite_pkg::*;
(
	input  logic      pixel_clk,
	input  logic      arst_n,
	input  scan_t     scan,
	input  logic      frame_tick,
	input  coord_t    player_x,
	input  coord_t    player_y,
	output layer_px_t coin_px,
	output score_t    score
);

	localparam int TILE_PX = 1 << `TILE_SHIFT;

	coin_mask_t taken;
	coin_mask_t taken_next;
	score_t     score_next;
	layer_px_t  px_next;
	logic [`TILE_SHIFT-1:0] off_x;
	logic [`TILE_SHIFT-1:0] off_y;
	logic       in_core;  // inner 8x8 of the tile

	// two 16 pixel spans starting at a and b overlap
	function automatic logic spans_overlap(coord_t a, coord_t b);
		logic [10:0] a_ext;
		logic [10:0] b_ext;
		a_ext = {1'b0, a};
		b_ext = {1'b0, b};
		return (a_ext < b_ext + 11'(TILE_PX)) && (b_ext < a_ext + 11'(TILE_PX));
	endfunction

	function automatic coord_t tile_origin(tile_idx_t t);
		return coord_t'(t) << `TILE_SHIFT;
	endfunction

	// player hit test once per frame
	always_comb
	begin
		taken_next = taken;
		score_next = '0;
		if (frame_tick)
		begin
			for (int i = 0; i < `NUM_COINS; i++)
			begin
				if (spans_overlap(player_x, tile_origin(COIN_COL[i])) &&
					spans_overlap(player_y, tile_origin(COIN_ROW[i])))
					taken_next[i] = 1'b1;
			end
		end
		// score follows the new mask so both change on the same edge
		for (int i = 0; i < `NUM_COINS; i++)
			score_next = score_next + (taken_next[i] ? score_t'(`COIN_POINTS) : score_t'(0));
	end

	always_comb
	begin
		off_x   = scan.draw_x[`TILE_SHIFT-1:0];
		off_y   = scan.draw_y[`TILE_SHIFT-1:0];
		in_core = (off_x >= 4'd4) && (off_x <= 4'd11) && (off_y >= 4'd4) && (off_y <= 4'd11);
		px_next.opaque = 1'b0;
		px_next.idx    = color_idx_t'(`IDX_COIN);
		for (int i = 0; i < `NUM_COINS; i++)
		begin
			if (!taken[i] && in_core &&
				((scan.draw_x >> `TILE_SHIFT) == coord_t'(COIN_COL[i])) &&
				((scan.draw_y >> `TILE_SHIFT) == coord_t'(COIN_ROW[i])))
				px_next.opaque = 1'b1;
		end
	end

	always_ff @(posedge pixel_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			taken   <= '0;
			score   <= '0;
			coin_px <= '0;
		end
		else
		begin
			taken   <= taken_next;
			score   <= score_next;
			coin_px <= px_next;
		end
	end

	// a collected coin stays collected until reset
	a_taken_sticky: assert property (@(posedge pixel_clk) disable iff (!arst_n)
		((~taken) & $past(taken)) == '0);

endmodule

/* hw/pixel_compositor.sv */
`timescale 1ns/10ps
`include "sprite_params.svh"

module pixel_compositor
	import sprite_pkg::*;
(
	input  logic      pixel_clk,
	input  logic      arst_n,
	input  scan_t     scan,
	input  layer_px_t tile_px,
	input  layer_px_t coin_px,
	input  coord_t    player_x,
	input  coord_t    player_y,
	output rgb_t      color,
	output logic      hs,
	output logic      vs
);

	localparam int BOX_SIZE = 1 << `TILE_SHIFT;  // player is one tile big

	scan_t      scan_d;  // lines up with the layer registers
	logic       in_player;
	color_idx_t idx;

	function automatic logic in_span(coord_t pos, coord_t start);
		logic [10:0] pos_ext;
		logic [10:0] start_ext;
		pos_ext   = {1'b0, pos};
		start_ext = {1'b0, start};
		return (pos_ext >= start_ext) && (pos_ext < start_ext + 11'(BOX_SIZE));
	endfunction

	function automatic rgb_t palette(color_idx_t i);
		rgb_t c;
		c.red   = i[3:0];
		c.green = (i == '0) ? 4'h0 : ~i[3:0];
		c.blue  = {4{i[4]}};
		return c;
	endfunction

	always_ff @(posedge pixel_clk or negedge arst_n)
	begin
		if (!arst_n)
			scan_d <= '{draw_x: '0, draw_y: '0, hs: 1'b1, vs: 1'b1, blank: 1'b0};
		else
			scan_d <= scan;
	end

	always_comb
	begin
		in_player = in_span(scan_d.draw_x, player_x) && in_span(scan_d.draw_y, player_y);
		if (!scan_d.blank)
			idx = color_idx_t'(`IDX_BLACK);
		else if (coin_px.opaque)
			idx = coin_px.idx;  // coins sit above the player
		else if (in_player)
			idx = color_idx_t'(`IDX_PLAYER);
		else if (tile_px.opaque)
			idx = tile_px.idx;
		else
			idx = color_idx_t'(`IDX_SKY);
	end

	always_ff @(posedge pixel_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			color <= '0;
			hs    <= 1'b1;
			vs    <= 1'b1;
		end
		else
		begin
			color <= palette(idx);
			hs    <= scan_d.hs;
			vs    <= scan_d.vs;
		end
	end

	a_black_in_blank: assert property (@(posedge pixel_clk) disable iff (!arst_n)
		!$past(scan_d.blank) |-> (color == '0));

endmodule

/* hw/vga_sprite_top.sv */
`timescale 1ns/10ps

module vga_sprite_top
	import sprite_pkg::*;
(
	input  logic       pixel_clk,
	input  logic       arst_n,
	input  coord_t     player_x,
	input  coord_t     player_y,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue,
	output logic       hs,
	output logic       vs,
	output score_t     score
);

	scan_t     scan;
	logic      frame_tick;
	layer_px_t tile_px;
	layer_px_t coin_px;
	rgb_t      color;

	vga_timing i_timing (.pixel_clk, .arst_n, .scan, .frame_tick);

	// both layers answer one cycle after the scan position
	tile_layer i_tile (.pixel_clk, .arst_n, .scan, .tile_px);

	coin_layer i_coin (
		.pixel_clk, .arst_n, .scan, .frame_tick,
		.player_x, .player_y, .coin_px, .score
	);

	pixel_compositor i_comp (
		.pixel_clk, .arst_n, .scan, .tile_px, .coin_px,
		.player_x, .player_y, .color, .hs, .vs
	);

	assign red   = color.red;
	assign green = color.green;
	assign blue  = color.blue;

endmodule

/* testbench/tb_vga_tasks.svh */
`ifndef TB_VGA_TASKS_SVH
`define TB_VGA_TASKS_SVH

// one clock step, sampled 1 ns after the edge, follows the output scan position
task automatic step();
	@(posedge pixel_clk);
	#1;
	hs_rose = hs && !prev_hs;
	hs_fell = !hs && prev_hs;
	vs_rose = vs && !prev_vs;
	vs_fell = !vs && prev_vs;
	if (vs_rose)
	begin
		next_line = 492;  // vs rises at the start of line 492
		known     = 1'b1;
	end
	if (hs_rose)
	begin
		cyc       = 0;
		next_line = (next_line + 1) % 525;
	end
	else
		cyc++;
	prev_hs = hs;
	prev_vs = vs;
endtask

// pixel x of next_line shows 48 + x cycles after the hs rise
task automatic wait_pixel(input int x, input int y);
	step();
	while (!(known && next_line == y && cyc == 48 + x))
		step();
endtask

task automatic wait_vs_rise();
	step();
	while (!vs_rose)
		step();
endtask

// called right after a step, so this lands 2 ns after the edge
task automatic set_player(input int x, input int y);
	#1;
	player_x = coord_t'(x);
	player_y = coord_t'(y);
	px_model = x;
	py_model = y;
endtask

task automatic check_rgb(input rgb_t actual, input rgb_t expected, input string msg);
	if (actual !== expected)
	begin
		rgb_errors++;
		$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, actual, expected);
	end
endtask

task automatic check_score(input score_t actual, input score_t expected, input string msg);
	if (actual !== expected)
	begin
		score_errors++;
		$display("CHECK FAILED at %0t: %s score %0d expected %0d", $time, msg, actual,
			expected);
	end
endtask

task automatic check_cycles(input int actual, input int expected, input string msg);
	if (actual != expected)
	begin
		timing_errors++;
		$display("CHECK FAILED at %0t: %s %0d cycles expected %0d", $time, msg, actual,
			expected);
	end
endtask

task automatic check_pixel(input int x, input int y);
	rgb_t actual;
	wait_pixel(x, y);
	actual = '{red: red, green: green, blue: blue};
	check_rgb(actual, expected_rgb(x, y), $sformatf("pixel %0d,%0d", x, y));
endtask

`endif

/* testbench/tb_vga_sprite.sv */
`timescale 1ns/10ps
`include "sprite_params.svh"

module tb_vga_sprite
	import sprite_pkg::*;
;

	localparam int TIMEOUT_CYCLES = 8 * 800 * 525;  // eight frames
	localparam int COIN_X [4] = '{5, 12, 20, 30};    // coin tile columns, all on row 20

	logic   pixel_clk;
	logic   arst_n;
	coord_t player_x;
	coord_t player_y;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;
	logic   hs;
	logic   vs;
	score_t score;

	// output scan tracking
	logic prev_hs = 1'b1;
	logic prev_vs = 1'b1;
	logic hs_rose;
	logic hs_fell;
	logic vs_rose;
	logic vs_fell;
	logic known = 1'b0;
	int   next_line = 0;
	int   cyc = 0;

	int px_model;
	int py_model;
	logic [3:0] taken_model = '0;
	int rgb_errors = 0;
	int score_errors = 0;
	int timing_errors = 0;
	int cycles = 0;
	integer seed = 32'h40487366;

	vga_sprite_top i_dut (.pixel_clk, .arst_n, .player_x, .player_y,
		.red, .green, .blue, .hs, .vs, .score);

	// colour index from the map, coin, player and priority rules
	function automatic int expected_idx(input int x, input int y);
		int col;
		int row;
		col = x / 16;
		row = y / 16;
		if (x >= 640 || y >= 480)
			return 0;
		for (int i = 0; i < 4; i++)
			if (!taken_model[i] && col == COIN_X[i] && row == 20 &&
				x % 16 >= 4 && x % 16 <= 11 && y % 16 >= 4 && y % 16 <= 11)
				return 12;
		if (x >= px_model && x < px_model + 16 && y >= py_model && y < py_model + 16)
			return 20;
		if (row >= 27 || col == 0 || col == 39)
			return (y % 16 == 0) ? 6 : 7;
		return 1;
	endfunction

	function automatic rgb_t expected_rgb(input int x, input int y);
		logic [4:0] i;
		rgb_t c;
		i = 5'(expected_idx(x, y));
		c.red   = i[3:0];
		c.green = (i == 0) ? 4'h0 : ~i[3:0];
		c.blue  = {4{i[4]}};
		return c;
	endfunction

	`include "tb_vga_tasks.svh"

	initial
	begin
		pixel_clk = 1'b0;
		forever #20 pixel_clk = ~pixel_clk;
	end

	// hang guard
	initial
	begin
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge pixel_clk);
			cycles++;
		end
		$display("the run timed out after %0d cycles", cycles);
		$display("test failed");
		$finish;
	end

	task automatic test_sync();
		int n;
		check_score(score, 0, "after reset");
		while (!known)
			step();
		step();
		while (!hs_fell)
			step();
		n = 0;
		step();
		while (!hs_rose)
		begin
			n++;
			step();
		end
		check_cycles(n + 1, 96, "hs low");
		step();
		while (!hs_fell)
		begin
			n++;
			step();
		end
		check_cycles(n + 2, 800, "line length");
		check_pixel(700, 10);  // horizontal blanking
		step();
		while (!vs_fell)
			step();
		n = 0;
		step();
		while (!vs_rose)
		begin
			n++;
			step();
		end
		check_cycles(n + 1, 1600, "vs low");
	endtask

	task automatic test_background();
		check_pixel(8, 48);
		check_pixel(8, 50);
		check_pixel(300, 200);
		check_pixel(632, 200);
		check_pixel(100, 432);
		check_pixel(100, 440);
		check_pixel(500, 470);
	endtask

	task automatic test_coins();
		set_player(16 + $unsigned($random(seed)) % 600, 16 + $unsigned($random(seed)) % 200);
		for (int i = 0; i < 4; i++)
			check_pixel(COIN_X[i] * 16 + 1, 321);
		for (int i = 0; i < 4; i++)
			check_pixel(COIN_X[i] * 16 + 8, 328);
	endtask

	task automatic test_collect();
		set_player(192, 320);
		wait_vs_rise();
		taken_model[1] = 1'b1;
		check_score(score, 7, "coin 1 taken");
		set_player(320, 100);
		for (int i = 0; i < 4; i++)
			check_pixel(COIN_X[i] * 16 + 8, 328);
		wait_vs_rise();
		check_score(score, 7, "coin 1 stays taken");
	endtask

	task automatic test_player();
		set_player(320, 320);  // over coin 2, leaves before frame_tick
		check_pixel(322, 322);
		check_pixel(328, 328);
		set_player(320, 430);
		check_pixel(325, 440);
		check_pixel(340, 440);
		set_player(80, 320);
		wait_vs_rise();
		set_player(320, 320);
		wait_vs_rise();
		set_player(480, 320);
		wait_vs_rise();
		check_score(score, 28, "all coins");
	endtask

	initial
	begin
		arst_n   = 1'b0;
		player_x = coord_t'(320);
		player_y = coord_t'(100);
		px_model = 320;
		py_model = 100;
		repeat (10) @(posedge pixel_clk);
		#2;
		arst_n = 1'b1;
		test_sync();
		test_background();
		test_coins();
		test_collect();
		test_player();
		$display("errors: rgb %0d, score %0d, timing %0d", rgb_errors, score_errors,
			timing_errors);
		if (rgb_errors + score_errors + timing_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+hw
+incdir+testbench
hw/sprite_pkg.sv
hw/vga_timing.sv
hw/tile_layer.sv
hw/coin_layer.sv
hw/pixel_compositor.sv
hw/vga_sprite_top.sv
testbench/tb_vga_sprite.sv
